/* build.f */
+incdir+source
source/ex_pkg.sv
source/ex_alu.sv
source/ex_multiplier.sv
source/ex_divider.sv
source/ex_stage.sv
tests/tb_clock_gen.sv
tests/ex_stage_properties.sv
tests/tb_ex_stage.sv

/* run_sim.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_ex_stage -f build.f -o sim_ex_stage

# tee keeps the pipeline status at zero so the log check below decides
./obj_dir/sim_ex_stage 2>&1 | tee sim.log

if grep -q "SIMULATION FAILED" sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
if ! grep -q "SIMULATION PASSED" sim.log; then
    echo "simulation ended without a pass line, see sim.log"
    exit 1
fi
echo "simulation passed"

/* source/ex_alu.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_alu (
    input  wire ex_pkg::alu_op_e  alu_op,
    input  wire  [`EX_XLEN-1:0]   src1,
    input  wire  [`EX_XLEN-1:0]   src2,
    output logic [`EX_XLEN-1:0]   result
);
    import ex_pkg::*;

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt = src2[4:0];
    assign lt_signed = $signed(src1) < $signed(src2);
    assign lt_unsigned = src1 < src2;

    always_comb begin
        case (alu_op)
            ALU_ADD: begin
                result = src1 + src2;
            end
            ALU_SUB: begin
                result = src1 - src2;
            end
            ALU_SLT: begin
                result = {{(`EX_XLEN-1){1'b0}}, lt_signed};
            end
            ALU_SLTU: begin
                result = {{(`EX_XLEN-1){1'b0}}, lt_unsigned};
            end
            ALU_AND: result = src1 & src2;
            ALU_OR:  result = src1 | src2;
            ALU_NOR: result = ~(src1 | src2);
            ALU_XOR: result = src1 ^ src2;
            ALU_SLL: result = src1 << shamt;
            ALU_SRL: result = src1 >> shamt;
            ALU_SRA: begin
                result = $signed(src1) >>> shamt;
            end
            // upper immediate already placed by decode
            ALU_LUI: result = src2;
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/ex_divider.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_divider (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 flush,
    input  wire                 start,
    input  wire                 is_signed,
    input  wire  [`EX_XLEN-1:0] dividend,
    input  wire  [`EX_XLEN-1:0] divisor,
    input  wire                 ack,
    output logic                done,
    output logic [`EX_XLEN-1:0] quotient,
    output logic [`EX_XLEN-1:0] remainder
);
    import ex_pkg::*;

    localparam int CNT_W = $clog2(`EX_DIV_STEPS + 1);
    localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(`EX_DIV_STEPS);

    div_state_e          state;
    logic [CNT_W-1:0]    step;
    logic [`EX_XLEN-1:0] acc;
    logic [`EX_XLEN-1:0] quo;
    logic [`EX_XLEN-1:0] dsr;
    logic                neg_q;
    logic                neg_r;
    logic                dividend_neg;
    logic                divisor_neg;
    logic [`EX_XLEN-1:0] dividend_mag;
    logic [`EX_XLEN-1:0] divisor_mag;
    logic [`EX_XLEN:0]   partial;
    logic [`EX_XLEN:0]   trial;

    assign dividend_neg = is_signed & dividend[`EX_XLEN-1];
    assign divisor_neg = is_signed & divisor[`EX_XLEN-1];
    assign dividend_mag = dividend_neg ? -dividend : dividend;
    assign divisor_mag = divisor_neg ? -divisor : divisor;

    // bring down next dividend bit, trial subtract
    assign partial = {acc, quo[`EX_XLEN-1]};
    assign trial = partial - {1'b0, dsr};

    assign done = (state == DIV_DONE);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            state <= DIV_IDLE;
            step <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (start) begin
                        state <= DIV_BUSY;
                        step <= '0;
                    end
                end
                DIV_BUSY: begin
                    // extra step at the end for the sign fixup
                    if (step == LAST_STEP) begin
                        state <= DIV_DONE;
                    end
                    step <= step + 1'b1;
                end
                DIV_DONE: begin
                    if (ack) begin
                        state <= DIV_IDLE;
                    end
                end
                default: state <= DIV_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DIV_IDLE && start) begin
            acc <= '0;
            quo <= dividend_mag;
            dsr <= divisor_mag;
            // x/0 keeps the all-ones quotient
            neg_q <= (dividend_neg ^ divisor_neg) && (divisor != '0);
            neg_r <= dividend_neg;
        end else if (state == DIV_BUSY) begin
            if (step != LAST_STEP) begin
                if (trial[`EX_XLEN]) begin
                    acc <= partial[`EX_XLEN-1:0];
                    quo <= {quo[`EX_XLEN-2:0], 1'b0};
                end else begin
                    acc <= trial[`EX_XLEN-1:0];
                    quo <= {quo[`EX_XLEN-2:0], 1'b1};
                end
            end else begin
                quotient <= neg_q ? -quo : quo;
                remainder <= neg_r ? -acc : acc;
            end
        end
    end

endmodule

`default_nettype wire

/* source/ex_multiplier.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_multiplier (
    input  wire                     clk,
    input  wire                     rst,
    input  wire  [`EX_XLEN-1:0]     src1,
    input  wire  [`EX_XLEN-1:0]     src2,
    input  wire                     is_unsigned,
    output logic [2*`EX_XLEN+1:0]   product
);

    logic [`EX_XLEN:0] ext1;
    logic [`EX_XLEN:0] ext2;

    // one extra bit lets a single signed multiply cover mulhu too
    assign ext1 = {~is_unsigned & src1[`EX_XLEN-1], src1};
    assign ext2 = {~is_unsigned & src2[`EX_XLEN-1], src2};

    always_ff @(posedge clk) begin
        if (rst) begin
            product <= '0;
        end else begin
            product <= $signed(ext1) * $signed(ext2);
        end
    end

endmodule

`default_nettype wire

/* source/ex_params.svh */
`ifndef EX_PARAMS_SVH
`define EX_PARAMS_SVH

// data path width, fixed by the instruction set
`define EX_XLEN 32

// register file address width
`define EX_RADDR_W 5

// one quotient bit per iteration
`define EX_DIV_STEPS 32

`endif

/* source/ex_pkg.sv */
`default_nettype none

`include "ex_params.svh"

package ex_pkg;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI
    } alu_op_e;

    // result sources other than the alu
    typedef enum logic [3:0] {
        MD_NONE, MD_MUL, MD_MULH, MD_MULHU,
        MD_DIV, MD_MOD, MD_DIVU, MD_MODU,
        MD_RDCNTVL, MD_RDCNTVH
    } md_op_e;

    typedef enum logic [3:0] {
        MEM_NONE, MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU,
        MEM_LD_W, MEM_ST_B, MEM_ST_H, MEM_ST_W
    } mem_op_e;

    typedef enum logic [1:0] {
        DIV_IDLE, DIV_BUSY, DIV_DONE
    } div_state_e;

    typedef struct packed {
        logic [`EX_XLEN-1:0]    pc;
        logic [`EX_XLEN-1:0]    src1;
        logic [`EX_XLEN-1:0]    src2;
        logic [`EX_XLEN-1:0]    rkd_value;
        alu_op_e                alu_op;
        md_op_e                 md_op;
        mem_op_e                mem_op;
        logic                   gr_we;
        logic [`EX_RADDR_W-1:0] rf_waddr;
        logic [8:0]             except_in;
    } id_to_ex_t;

    typedef struct packed {
        logic [`EX_XLEN-1:0]    pc;
        logic [`EX_XLEN-1:0]    result;
        logic [`EX_XLEN-1:0]    rkd_value;
        mem_op_e                mem_op;
        logic                   gr_we;
        logic [`EX_RADDR_W-1:0] rf_waddr;
        // except_in with ale in bit 0
        logic [9:0]             except_out;
    } ex_to_mem_t;

    typedef struct packed {
        logic                   valid;
        logic [`EX_RADDR_W-1:0] addr;
        logic [`EX_XLEN-1:0]    data;
        logic                   is_load;
    } ex_bypass_t;

endpackage

`default_nettype wire

/* source/ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage (
    input  wire                     clk,
    input  wire                     rst,
    input  wire                     flush,
    input  wire                     in_valid,
    input  wire ex_pkg::id_to_ex_t  in_inst,
    output logic                    allowin,
    output logic                    out_valid,
    output ex_pkg::ex_to_mem_t      out_inst,
    input  wire                     mem_allowin,
    output ex_pkg::ex_bypass_t      bypass,
    input  wire  [2*`EX_XLEN-1:0]   counter
);
    import ex_pkg::*;

    id_to_ex_t             inst_q;
    logic                  occupied;
    logic                  first;
    logic                  div_wait;
    logic                  ready_go;
    logic                  accept;
    logic                  leave;
    logic                  is_div;
    logic                  is_load;
    logic                  div_start;
    logic                  div_ack;
    logic                  div_done;
    logic                  except_ale;
    logic [`EX_XLEN-1:0]   alu_result;
    logic [`EX_XLEN-1:0]   quotient;
    logic [`EX_XLEN-1:0]   remainder;
    logic [`EX_XLEN-1:0]   result;
    logic [2*`EX_XLEN+1:0] product;

    assign accept = in_valid & allowin & ~flush;
    assign leave = out_valid & mem_allowin;
    assign out_valid = occupied & ready_go & ~flush;
    assign allowin = ~occupied | leave;

    assign is_div = inst_q.md_op inside {MD_DIV, MD_MOD, MD_DIVU, MD_MODU};
    assign is_load = inst_q.mem_op inside {MEM_LD_B, MEM_LD_BU, MEM_LD_H,
                                           MEM_LD_HU, MEM_LD_W};

    // divider kicked off in the cycle after acceptance
    assign div_start = first & is_div;
    assign div_ack = div_wait & div_done;

    always_ff @(posedge clk) begin
        if (accept) begin
            inst_q <= in_inst;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            occupied <= 1'b0;
            first <= 1'b0;
            div_wait <= 1'b0;
            ready_go <= 1'b0;
        end else begin
            first <= accept;
            if (accept) begin
                occupied <= 1'b1;
            end else if (leave) begin
                occupied <= 1'b0;
            end
            if (div_start) begin
                div_wait <= 1'b1;
            end else if (div_ack) begin
                div_wait <= 1'b0;
            end
            // one cycle covers the registered product
            if ((first && !is_div) || div_ack) begin
                ready_go <= 1'b1;
            end else if (leave) begin
                ready_go <= 1'b0;
            end
        end
    end

    ex_alu u_alu (
        .alu_op (inst_q.alu_op),
        .src1   (inst_q.src1),
        .src2   (inst_q.src2),
        .result (alu_result)
    );

    ex_multiplier u_mul (
        .clk         (clk),
        .rst         (rst),
        .src1        (inst_q.src1),
        .src2        (inst_q.src2),
        .is_unsigned (inst_q.md_op == MD_MULHU),
        .product     (product)
    );

    ex_divider u_div (
        .clk       (clk),
        .rst       (rst),
        .flush     (flush),
        .start     (div_start),
        .is_signed (inst_q.md_op inside {MD_DIV, MD_MOD}),
        .dividend  (inst_q.src1),
        .divisor   (inst_q.src2),
        .ack       (div_ack),
        .done      (div_done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    always_comb begin
        case (inst_q.md_op)
            MD_MUL:              result = product[`EX_XLEN-1:0];
            MD_MULH, MD_MULHU:   result = product[2*`EX_XLEN-1:`EX_XLEN];
            MD_DIV, MD_DIVU:     result = quotient;
            MD_MOD, MD_MODU:     result = remainder;
            MD_RDCNTVL:          result = counter[`EX_XLEN-1:0];
            MD_RDCNTVH:          result = counter[2*`EX_XLEN-1:`EX_XLEN];
            default:             result = alu_result;
        endcase
    end

    // address misalignment on the alu-computed address
    always_comb begin
        case (inst_q.mem_op)
            MEM_LD_W, MEM_ST_W:            except_ale = |alu_result[1:0];
            MEM_LD_H, MEM_LD_HU, MEM_ST_H: except_ale = alu_result[0];
            default:                       except_ale = 1'b0;
        endcase
    end

    assign out_inst.pc = inst_q.pc;
    assign out_inst.result = result;
    assign out_inst.rkd_value = inst_q.rkd_value;
    assign out_inst.mem_op = inst_q.mem_op;
    assign out_inst.gr_we = inst_q.gr_we;
    assign out_inst.rf_waddr = inst_q.rf_waddr;
    assign out_inst.except_out = {inst_q.except_in, except_ale};

    assign bypass.valid = occupied & inst_q.gr_we & ~is_load;
    assign bypass.addr = inst_q.rf_waddr;
    assign bypass.data = result;
    assign bypass.is_load = occupied & is_load;

endmodule

`default_nettype wire

/* tests/ex_stage_properties.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module ex_stage_properties (
    input wire                      clk,
    input wire                      rst,
    input wire                      allowin,
    input wire                      out_valid,
    input wire                      mem_allowin,
    input wire ex_pkg::ex_to_mem_t  out_inst,
    input wire ex_pkg::div_state_e  div_state,
    input wire                      div_done
);
    import ex_pkg::*;

    // stalled output blocks new input
    stall_blocks_input: assert property (@(posedge clk) disable iff (rst)
        out_valid && !mem_allowin |-> !allowin)
        else $error("allowin high while the output is stalled");

    stall_holds_output: assert property (@(posedge clk) disable iff (rst)
        out_valid && !mem_allowin |=> $stable(out_inst))
        else $error("out_inst changed during a stall");

    // busy for the full step count, entered straight from idle
    done_after_busy: assert property (@(posedge clk) disable iff (rst)
        $rose(div_done) |-> $past(div_state, `EX_DIV_STEPS + 1) == DIV_BUSY
            && $past(div_state, `EX_DIV_STEPS + 2) == DIV_IDLE)
        else $error("divider done raised without a full busy phase");

endmodule

bind ex_stage ex_stage_properties props0 (
    .clk         (clk),
    .rst         (rst),
    .allowin     (allowin),
    .out_valid   (out_valid),
    .mem_allowin (mem_allowin),
    .out_inst    (out_inst),
    .div_state   (u_div.state),
    .div_done    (div_done)
);

`default_nettype wire

/* tests/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // held through the first 8 rising edges
    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

/* tests/tb_ex_stage.sv */
`timescale 1ns/1ps
`default_nettype none

`include "ex_params.svh"

module tb_ex_stage;
    import ex_pkg::*;

    // about 200 instructions of up to 40 cycles each
    localparam int MAX_CYCLES = 200 * 40;

    logic                  clk;
    logic                  rst;
    logic                  flush;
    logic                  in_valid;
    id_to_ex_t             in_inst;
    logic                  allowin;
    logic                  out_valid;
    ex_to_mem_t            out_inst;
    logic                  mem_allowin;
    ex_bypass_t            bypass;
    logic [2*`EX_XLEN-1:0] counter;

    logic [31:0] lfsr_q;
    int          cycle_count = 0;
    int          deliveries = 0;
    int          error_count;
    logic        passed;
    logic        fail_printed;

    tb_clock_gen clkgen0 (
        .clk (clk),
        .rst (rst)
    );

    ex_stage dut0 (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .in_valid    (in_valid),
        .in_inst     (in_inst),
        .allowin     (allowin),
        .out_valid   (out_valid),
        .out_inst    (out_inst),
        .mem_allowin (mem_allowin),
        .bypass      (bypass),
        .counter     (counter)
    );

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            fail_printed = 1'b1;
            $display("SIMULATION FAILED");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    // instructions handed to the memory stage
    always @(posedge clk) begin
        if (!rst && out_valid && mem_allowin) begin
            deliveries++;
        end
    end

    final begin
        if (!passed && !fail_printed) begin
            $display("SIMULATION FAILED");
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand32(output logic [31:0] v);
        int i;
        v = '0;
        for (i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
            fail_printed = 1'b1;
            $display("SIMULATION FAILED");
            $fatal(1, "value check failed");
        end
    endtask

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [63:0] ext;
        logic        less;
        ext = {{32{a[31]}}, a} >> b[4:0];
        // differing signs decide the signed compare alone
        less = (a[31] != b[31]) ? a[31] : (a < b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a + ~b + 32'd1;
            ALU_SLT:  return {31'b0, less};
            ALU_SLTU: return {31'b0, a < b};
            ALU_AND:  return a & b;
            ALU_OR:   return a | b;
            ALU_NOR:  return ~a & ~b;
            ALU_XOR:  return a ^ b;
            ALU_SLL:  return a << b[4:0];
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return ext[31:0];
            default:  return b;
        endcase
    endfunction

    function automatic logic [31:0] mul_model(input md_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [63:0] sp;
        logic        [63:0] up;
        sp = $signed({{32{a[31]}}, a}) * $signed({{32{b[31]}}, b});
        up = {32'b0, a} * {32'b0, b};
        case (op)
            MD_MUL:  return sp[31:0];
            MD_MULH: return sp[63:32];
            default: return up[63:32];
        endcase
    endfunction

    function automatic logic [31:0] div_model(input md_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] sq;
        logic signed [63:0] sr;
        logic        [31:0] uq;
        logic        [31:0] ur;
        sa = {{32{a[31]}}, a};
        sb = {{32{b[31]}}, b};
        if (b == 32'd0) begin
            sq = '1;
            sr = sa;
            uq = '1;
            ur = a;
        end else begin
            sq = sa / sb;
            sr = sa % sb;
            uq = a / b;
            ur = a % b;
        end
        case (op)
            MD_DIV:  return sq[31:0];
            MD_MOD:  return sr[31:0];
            MD_DIVU: return uq;
            default: return ur;
        endcase
    endfunction

    function automatic logic align_fault(input mem_op_e op, input logic [1:0] lo);
        case (op)
            MEM_LD_W, MEM_ST_W:            return lo != 2'b00;
            MEM_LD_H, MEM_LD_HU, MEM_ST_H: return lo[0];
            default:                       return 1'b0;
        endcase
    endfunction

    task automatic make_inst(output id_to_ex_t inst, input alu_op_e alu_op,
                             input md_op_e md_op, input mem_op_e mem_op,
                             input logic [31:0] a, input logic [31:0] b, input logic gr_we);
        logic [31:0] r;
        inst = '0;
        rand32(inst.pc);
        rand32(inst.rkd_value);
        rand32(r);
        inst.rf_waddr = r[4:0];
        inst.except_in = r[16:8];
        inst.src1 = a;
        inst.src2 = b;
        inst.alu_op = alu_op;
        inst.md_op = md_op;
        inst.mem_op = mem_op;
        inst.gr_we = gr_we;
    endtask

    task automatic issue_inst(input id_to_ex_t inst);
        while (!allowin) begin
            @(negedge clk);
        end
        in_inst = inst;
        in_valid = 1'b1;
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    // lat counts cycles from acceptance until out_valid
    task automatic run_inst(input id_to_ex_t inst, output ex_to_mem_t out,
                            output ex_bypass_t byp, output int lat);
        issue_inst(inst);
        lat = 0;
        while (!out_valid) begin
            @(negedge clk);
            lat++;
        end
        out = out_inst;
        byp = bypass;
    endtask

    task automatic check_fields(input id_to_ex_t inst, input ex_to_mem_t out,
                                input ex_bypass_t byp, input logic [31:0] exp_result);
        logic load;
        logic exp_bvalid;
        logic ale;
        load = inst.mem_op inside {MEM_LD_B, MEM_LD_BU, MEM_LD_H, MEM_LD_HU, MEM_LD_W};
        exp_bvalid = inst.gr_we & ~load;
        ale = align_fault(inst.mem_op, exp_result[1:0]);
        check_value("out_inst.result", out.result, exp_result);
        check_value("out_inst.pc", out.pc, inst.pc);
        check_value("out_inst.rkd_value", out.rkd_value, inst.rkd_value);
        check_value("out_inst.mem_op", 32'(out.mem_op), 32'(inst.mem_op));
        check_value("out_inst.gr_we", 32'(out.gr_we), 32'(inst.gr_we));
        check_value("out_inst.rf_waddr", 32'(out.rf_waddr), 32'(inst.rf_waddr));
        check_value("out_inst.except_out", 32'(out.except_out), 32'({inst.except_in, ale}));
        check_value("bypass.valid", 32'(byp.valid), 32'(exp_bvalid));
        check_value("bypass.is_load", 32'(byp.is_load), 32'(load));
        if (exp_bvalid) begin
            check_value("bypass.addr", 32'(byp.addr), 32'(inst.rf_waddr));
            check_value("bypass.data", byp.data, exp_result);
        end
    endtask

    task automatic test_alu();
        id_to_ex_t   inst;
        ex_to_mem_t  out;
        ex_bypass_t  byp;
        int          lat;
        int          k;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        for (k = 0; k < 12; k++) begin
            for (n = 0; n < 4; n++) begin
                rand32(a);
                rand32(b);
                make_inst(inst, alu_op_e'(k), MD_NONE, MEM_NONE, a, b, n != 3);
                run_inst(inst, out, byp, lat);
                check_value("alu latency", 32'(lat), 32'd1);
                check_fields(inst, out, byp, alu_model(alu_op_e'(k), a, b));
            end
        end
    endtask

    task automatic test_multiply();
        id_to_ex_t   inst;
        ex_to_mem_t  out;
        ex_bypass_t  byp;
        int          lat;
        int          k;
        int          n;
        logic [31:0] ma [6];
        logic [31:0] mb [6];
        rand32(ma[0]);
        rand32(mb[0]);
        rand32(ma[1]);
        rand32(mb[1]);
        ma[2] = 32'hffff_ff85;
        mb[2] = 32'h8000_0013;
        ma[3] = 32'h8000_0000;
        mb[3] = 32'h8000_0000;
        ma[4] = 32'hffff_ffff;
        mb[4] = 32'hffff_ffff;
        ma[5] = 32'h8000_0000;
        mb[5] = 32'h7fff_ffff;
        for (k = 0; k < 3; k++) begin
            for (n = 0; n < 6; n++) begin
                make_inst(inst, ALU_ADD, md_op_e'(k + 1), MEM_NONE, ma[n], mb[n], 1'b1);
                run_inst(inst, out, byp, lat);
                check_fields(inst, out, byp, mul_model(md_op_e'(k + 1), ma[n], mb[n]));
            end
        end
    endtask

    task automatic test_divide();
        id_to_ex_t   inst;
        ex_to_mem_t  out;
        ex_bypass_t  byp;
        int          lat;
        int          k;
        int          n;
        logic [31:0] da [7];
        logic [31:0] db [7];
        logic [31:0] r;
        rand32(da[0]);
        rand32(db[0]);
        rand32(da[1]);
        rand32(r);
        db[1] = {24'b0, r[7:0]} | 32'd1;
        da[2] = 32'hffff_ff9c;
        db[2] = 32'd7;
        da[3] = 32'd100;
        db[3] = 32'hffff_fff9;
        da[4] = 32'hffff_ff9c;
        db[4] = 32'hffff_fff9;
        rand32(da[5]);
        db[5] = 32'd0;
        da[6] = 32'h8000_0000;
        db[6] = 32'hffff_ffff;
        for (k = 0; k < 4; k++) begin
            for (n = 0; n < 7; n++) begin
                make_inst(inst, ALU_ADD, md_op_e'(k + 4), MEM_NONE, da[n], db[n], 1'b1);
                run_inst(inst, out, byp, lat);
                check_fields(inst, out, byp, div_model(md_op_e'(k + 4), da[n], db[n]));
            end
        end
    endtask

    task automatic test_alignment();
        id_to_ex_t   inst;
        ex_to_mem_t  out;
        ex_bypass_t  byp;
        int          lat;
        int          k;
        int          lo;
        logic [31:0] a;
        logic [31:0] b;
        // loads write a register, stores do not
        for (k = 1; k <= 8; k++) begin
            for (lo = 0; lo < 4; lo++) begin
                rand32(a);
                a = {a[31:2], 2'b00};
                b = {30'b0, 2'(lo)};
                make_inst(inst, ALU_ADD, MD_NONE, mem_op_e'(k), a, b, k <= 5);
                run_inst(inst, out, byp, lat);
                check_fields(inst, out, byp, a + b);
            end
        end
    endtask

    task automatic test_stall_flush();
        id_to_ex_t   inst;
        ex_to_mem_t  out;
        ex_bypass_t  byp;
        int          lat;
        int          start_count;
        logic [31:0] a;
        logic [31:0] b;
        rand32(a);
        rand32(b);
        // previous instruction drains first
        @(negedge clk);
        mem_allowin = 1'b0;
        make_inst(inst, ALU_ADD, MD_MUL, MEM_NONE, a, b, 1'b1);
        run_inst(inst, out, byp, lat);
        start_count = deliveries;
        repeat (6) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd1);
            check_value("allowin", 32'(allowin), 32'd0);
            check_value("out_inst.result", out_inst.result, out.result);
            check_value("out_inst.pc", out_inst.pc, out.pc);
        end
        mem_allowin = 1'b1;
        @(negedge clk);
        check_value("deliveries", 32'(deliveries - start_count), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_fields(inst, out, byp, mul_model(MD_MUL, a, b));

        // flush a division partway through
        make_inst(inst, ALU_ADD, MD_DIV, MEM_NONE, a, b, 1'b1);
        issue_inst(inst);
        repeat (5) @(negedge clk);
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        repeat (`EX_DIV_STEPS + 8) begin
            @(negedge clk);
            check_value("out_valid", 32'(out_valid), 32'd0);
            check_value("allowin", 32'(allowin), 32'd1);
        end
        make_inst(inst, ALU_ADD, MD_MODU, MEM_NONE, b, a, 1'b1);
        run_inst(inst, out, byp, lat);
        check_fields(inst, out, byp, div_model(MD_MODU, b, a));
    endtask

    task automatic test_counter();
        id_to_ex_t   inst;
        ex_to_mem_t  out;
        ex_bypass_t  byp;
        int          lat;
        logic [31:0] hi;
        logic [31:0] lo;
        rand32(hi);
        rand32(lo);
        counter = {hi, lo};
        make_inst(inst, ALU_ADD, MD_RDCNTVL, MEM_NONE, 32'd0, 32'd0, 1'b1);
        run_inst(inst, out, byp, lat);
        check_fields(inst, out, byp, lo);
        make_inst(inst, ALU_ADD, MD_RDCNTVH, MEM_NONE, 32'd0, 32'd0, 1'b1);
        run_inst(inst, out, byp, lat);
        check_fields(inst, out, byp, hi);
    endtask

    initial begin
        lfsr_q = 32'd94431;
        error_count = 0;
        passed = 1'b0;
        fail_printed = 1'b0;
        flush = 1'b0;
        in_valid = 1'b0;
        in_inst = '0;
        mem_allowin = 1'b1;
        counter = '0;
        @(negedge clk);
        while (rst) begin
            @(negedge clk);
        end
        check_value("allowin", 32'(allowin), 32'd1);
        check_value("out_valid", 32'(out_valid), 32'd0);
        check_value("bypass.valid", 32'(bypass.valid), 32'd0);
        check_value("divider done", 32'(dut0.div_done), 32'd0);
        test_alu();
        test_multiply();
        test_divide();
        test_alignment();
        test_stall_flush();
        test_counter();
        if (error_count == 0) begin
            passed = 1'b1;
            $display("SIMULATION PASSED");
        end else begin
            fail_printed = 1'b1;
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
